//--- hw/display_timings.sv
////////////////////
// active pixels come first in each line and frame; every porch must be at least 1
// outputs are registered and line up with sx/sy
////////////////////
`timescale 1ns/1ps

module display_timings #(
    parameter int H_RES  = 640,
    parameter int V_RES  = 480,
    parameter int H_FP   = 16,
    parameter int H_SYNC = 96,
    parameter int H_BP   = 48,
    parameter int V_FP   = 10,
    parameter int V_SYNC = 2,
    parameter int V_BP   = 33
) (
    input  logic clk_pix,
    input  logic rst,
    output gfx_pkg::coord_t sx,
    output gfx_pkg::coord_t sy,
    output logic hsync,
    output logic vsync,
    output logic de,
    output logic frame
);
    import gfx_pkg::*;

    localparam coord_t H_LAST = coord_t'(H_RES + H_FP + H_SYNC + H_BP - 1);
    localparam coord_t V_LAST = coord_t'(V_RES + V_FP + V_SYNC + V_BP - 1);
    localparam coord_t HS_STA = coord_t'(H_RES + H_FP);
    localparam coord_t HS_END = coord_t'(H_RES + H_FP + H_SYNC);
    localparam coord_t VS_STA = coord_t'(V_RES + V_FP);
    localparam coord_t VS_END = coord_t'(V_RES + V_FP + V_SYNC);

    coord_t sx_next, sy_next;

    always_comb begin
        sx_next = (sx == H_LAST) ? coord_t'(0) : sx + coord_t'(1);
        sy_next = sy;
        if (sx == H_LAST) begin
            sy_next = (sy == V_LAST) ? coord_t'(0) : sy + coord_t'(1);
        end
    end

    always_ff @(posedge clk_pix) begin
        if (rst) begin
            sx    <= H_LAST;  // park at the very last blanking pixel
            sy    <= V_LAST;
            hsync <= 1'b1;
            vsync <= 1'b1;
            de    <= 1'b0;
            frame <= 1'b0;
        end else begin
            sx    <= sx_next;
            sy    <= sy_next;
            hsync <= !(sx_next >= HS_STA && sx_next < HS_END);
            vsync <= !(sy_next >= VS_STA && sy_next < VS_END);
            de    <= (sx_next < coord_t'(H_RES)) && (sy_next < coord_t'(V_RES));
            frame <= (sx_next == 0) && (sy_next == V_LAST);  // line before row 0
        end
    end

endmodule

//--- hw/draw_sequencer.sv
////////////////////
// starts are taken only when idle; clear beats shape if both arrive together
// fill runs only while de is low, clear runs at one address per cycle
////////////////////
`timescale 1ns/1ps

module draw_sequencer #(
    parameter int H_RES = 640,
    parameter int V_RES = 480
) (
    input  logic clk_pix,
    input  logic rst,
    input  gfx_pkg::tri_shape_t shape,
    input  logic shape_start,
    input  logic clear_start,
    input  logic de,
    output logic draw_busy,
    output logic draw_done,
    output logic wr_en,
    output gfx_pkg::fb_wr_t wr
);
    import gfx_pkg::*;

    localparam coord_t X_LAST = coord_t'(H_RES - 1);
    localparam coord_t Y_LAST = coord_t'(V_RES - 1);

    typedef enum logic [1:0] {IDLE, CLEAR, DRAW, DONE} state_t;

    state_t state;
    tri_shape_t shape_q;
    coord_t cx, cy;  // clear walk position
    vertex_t clear_pos, fill_pix;
    logic clear_end, fill_start, fill_valid, fill_done;

    assign draw_busy = (state != IDLE);
    assign draw_done = (state == DONE);  // lasts one cycle
    assign clear_pos = '{x: cx, y: cy};

    always_ff @(posedge clk_pix) begin
        if (rst) begin
            state      <= IDLE;
            clear_end  <= 1'b0;
            fill_start <= 1'b0;
        end else begin
            fill_start <= 1'b0;
            case (state)
                IDLE: begin
                    if (clear_start) begin
                        state     <= CLEAR;
                        clear_end <= 1'b0;
                    end else if (shape_start) begin
                        state      <= DRAW;
                        fill_start <= 1'b1;
                    end
                end
                CLEAR: begin
                    if (clear_end) state <= DONE;
                    else if (cx == X_LAST && cy == Y_LAST) clear_end <= 1'b1;
                end
                DRAW: if (fill_done) state <= DONE;
                default: state <= IDLE;  // DONE
            endcase
        end
    end

    always_ff @(posedge clk_pix) begin
        if (state == IDLE) begin
            cx <= '0;
            cy <= '0;
            if (shape_start && !clear_start) shape_q <= shape;
        end else if (state == CLEAR && !clear_end) begin
            if (cx == X_LAST) begin
                cx <= '0;
                cy <= cy + coord_t'(1);
            end else begin
                cx <= cx + coord_t'(1);
            end
        end
    end

    draw_triangle_fill fill_inst (
        .clk_pix,
        .rst,
        .start(fill_start),
        .oe(!de),  // draw only during blanking
        .v0(shape_q.v0),
        .v1(shape_q.v1),
        .v2(shape_q.v2),
        .pix(fill_pix),
        .pix_valid(fill_valid),
        .busy(),
        .done(fill_done)
    );

    // registered write mux
    always_ff @(posedge clk_pix) begin
        if (rst) wr_en <= 1'b0;
        else wr_en <= (state == CLEAR && !clear_end) || fill_valid;
    end

    always_ff @(posedge clk_pix) begin
        wr.pos  <= (state == CLEAR) ? clear_pos : fill_pix;
        wr.cidx <= (state == CLEAR) ? cidx_t'(0) : shape_q.colour;
    end

endmodule

//--- hw/draw_triangle_fill.sv
////////////////////
// fills the bounding box in raster order, one candidate per oe cycle
// edges are inclusive, either winding works; start is ignored while busy
////////////////////
`timescale 1ns/1ps

module draw_triangle_fill (
    input  logic clk_pix,
    input  logic rst,
    input  logic start,
    input  logic oe,
    input  gfx_pkg::vertex_t v0,
    input  gfx_pkg::vertex_t v1,
    input  gfx_pkg::vertex_t v2,
    output gfx_pkg::vertex_t pix,
    output logic pix_valid,
    output logic busy,
    output logic done
);
    import gfx_pkg::*;

    localparam int EW = 2 * CORDW + 4;  // room for cross-product of 17-bit deltas

    typedef logic signed [EW-1:0] edge_t;
    typedef enum logic {IDLE, SCAN} state_t;

    state_t state;
    vertex_t p0, p1, p2;  // captured vertices
    coord_t x, y;
    coord_t x_min, x_max, y_min, y_max;
    edge_t e0, e1, e2;
    logic all_pos, all_neg;
    logic row_end, box_end;

    function automatic coord_t min3(coord_t a, coord_t b, coord_t c);
        coord_t m;
        m = (a < b) ? a : b;
        return (m < c) ? m : c;
    endfunction

    function automatic coord_t max3(coord_t a, coord_t b, coord_t c);
        coord_t m;
        m = (a > b) ? a : b;
        return (m > c) ? m : c;
    endfunction

    // cross product (b - a) x (p - a)
    function automatic edge_t edge_fn(vertex_t a, vertex_t b, coord_t px, coord_t py);
        edge_t abx, aby, apx, apy;
        abx = $signed(b.x) - $signed(a.x);
        aby = $signed(b.y) - $signed(a.y);
        apx = px - $signed(a.x);
        apy = py - $signed(a.y);
        return abx * apy - aby * apx;
    endfunction

    assign e0 = edge_fn(p0, p1, x, y);
    assign e1 = edge_fn(p1, p2, x, y);
    assign e2 = edge_fn(p2, p0, x, y);

    assign all_pos = (e0 >= 0) && (e1 >= 0) && (e2 >= 0);
    assign all_neg = (e0 <= 0) && (e1 <= 0) && (e2 <= 0);  // other winding

    assign row_end   = (x == x_max);
    assign box_end   = row_end && (y == y_max);
    assign busy      = (state == SCAN);
    assign pix       = '{x: x, y: y};
    assign pix_valid = busy && oe && (all_pos || all_neg);

    always_ff @(posedge clk_pix) begin
        if (rst) begin
            state <= IDLE;
            done  <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                IDLE: if (start) state <= SCAN;
                SCAN: begin
                    if (oe && box_end) begin  // last point visited
                        state <= IDLE;
                        done  <= 1'b1;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // vertex capture and scan position
    always_ff @(posedge clk_pix) begin
        if (start && state == IDLE) begin
            p0    <= v0;
            p1    <= v1;
            p2    <= v2;
            x_min <= min3(v0.x, v1.x, v2.x);
            x_max <= max3(v0.x, v1.x, v2.x);
            y_min <= min3(v0.y, v1.y, v2.y);
            y_max <= max3(v0.y, v1.y, v2.y);
            x     <= min3(v0.x, v1.x, v2.x);
            y     <= min3(v0.y, v1.y, v2.y);
        end else if (busy && oe) begin
            if (row_end) begin
                x <= x_min;
                y <= y + coord_t'(1);
            end else begin
                x <= x + coord_t'(1);
            end
        end
    end

endmodule

//--- hw/framebuffer.sv
////////////////////
// writes outside WIDTH x HEIGHT are dropped; contents are undefined until cleared
// pix follows sx/sy/de by one cycle and is black whenever de was low
////////////////////
`timescale 1ns/1ps

module framebuffer #(
    parameter int WIDTH  = 640,
    parameter int HEIGHT = 480
) (
    input  logic clk_pix,
    input  logic wr_en,
    input  gfx_pkg::fb_wr_t wr,
    input  gfx_pkg::coord_t sx,
    input  gfx_pkg::coord_t sy,
    input  logic de,
    output gfx_pkg::rgb_t pix
);
    import gfx_pkg::*;

    localparam int DEPTH = WIDTH * HEIGHT;
    localparam int AW    = $clog2(DEPTH);

    cidx_t mem [DEPTH];  // one colour index per pixel
    cidx_t rd_cidx;
    logic rd_de;
    logic wr_ok;
    logic [AW-1:0] wr_addr;
    logic [AW-1:0] rd_addr;

    function automatic logic in_bounds(coord_t x, coord_t y);
        return (x >= 0) && (x < WIDTH) && (y >= 0) && (y < HEIGHT);
    endfunction

    function automatic logic [AW-1:0] lin_addr(coord_t x, coord_t y);
        logic [AW-1:0] ax;
        logic [AW-1:0] ay;
        ax = AW'(x);
        ay = AW'(y);
        return ay * AW'(WIDTH) + ax;  // y*WIDTH+x
    endfunction

    assign wr_ok   = wr_en && in_bounds(wr.pos.x, wr.pos.y);  // clip
    assign wr_addr = lin_addr(wr.pos.x, wr.pos.y);
    assign rd_addr = in_bounds(sx, sy) ? lin_addr(sx, sy) : '0;

    always_ff @(posedge clk_pix) begin
        if (wr_ok) begin
            mem[wr_addr] <= wr.cidx;
        end
    end

    // scan-out port
    always_ff @(posedge clk_pix) begin
        rd_cidx <= mem[rd_addr];
        rd_de   <= de;
    end

    assign pix = rd_de ? PALETTE[rd_cidx] : rgb_t'(0);  // black in blanking

endmodule

//--- hw/gfx_pkg.sv
////////////////////
// coordinates are signed 16-bit, colour indices 4-bit into a fixed 12-bit palette
// palette entry 0 must stay black, since clearing writes index 0
////////////////////
package gfx_pkg;

    localparam int CORDW = 16;  // coordinate width

    typedef logic signed [CORDW-1:0] coord_t;
    typedef logic [3:0] cidx_t;

    typedef struct packed {
        logic [3:0] red;
        logic [3:0] green;
        logic [3:0] blue;
    } rgb_t;

    typedef struct packed {
        coord_t x;
        coord_t y;
    } vertex_t;

    typedef struct packed {
        vertex_t v0;
        vertex_t v1;
        vertex_t v2;
        cidx_t   colour;
    } tri_shape_t;

    typedef struct packed {
        logic hsync;  // active low
        logic vsync;  // active low
        logic de;
        rgb_t pix;
    } video_t;

    typedef struct packed {
        vertex_t pos;
        cidx_t   cidx;
    } fb_wr_t;

    localparam rgb_t PALETTE [16] = '{
        12'h000, 12'h123, 12'h725, 12'h085, 12'hA53, 12'h555, 12'hCCC, 12'hFFE,
        12'hF04, 12'hFA0, 12'hFE2, 12'h0E3, 12'h2AF, 12'h879, 12'hF7A, 12'hFCA
    };

endpackage

//--- hw/triangles_top.sv
////////////////////
// video trails the timing counters by two cycles (buffer read + output register)
// framebuffer size equals the active area H_RES x V_RES
////////////////////
`timescale 1ns/1ps

module triangles_top #(
    parameter int H_RES  = 640,
    parameter int V_RES  = 480,
    parameter int H_FP   = 16,
    parameter int H_SYNC = 96,
    parameter int H_BP   = 48,
    parameter int V_FP   = 10,
    parameter int V_SYNC = 2,
    parameter int V_BP   = 33
) (
    input  logic clk_pix,
    input  logic rst,
    input  gfx_pkg::tri_shape_t shape,
    input  logic shape_start,
    input  logic clear_start,
    output logic draw_busy,
    output logic draw_done,
    output gfx_pkg::video_t video
);
    import gfx_pkg::*;

    coord_t sx, sy;
    logic hsync, vsync, de;
    logic hsync_p1, vsync_p1, de_p1;
    logic wr_en;
    fb_wr_t wr;
    rgb_t fb_pix;

    display_timings #(
        .H_RES(H_RES), .V_RES(V_RES), .H_FP(H_FP), .H_SYNC(H_SYNC),
        .H_BP(H_BP), .V_FP(V_FP), .V_SYNC(V_SYNC), .V_BP(V_BP)
    ) timings_inst (
        .clk_pix, .rst, .sx, .sy, .hsync, .vsync, .de, .frame()
    );

    draw_sequencer #(.H_RES(H_RES), .V_RES(V_RES)) seq_inst (
        .clk_pix, .rst, .shape, .shape_start, .clear_start, .de,
        .draw_busy, .draw_done, .wr_en, .wr
    );

    framebuffer #(.WIDTH(H_RES), .HEIGHT(V_RES)) fb_inst (
        .clk_pix, .wr_en, .wr, .sx, .sy, .de, .pix(fb_pix)
    );

    always_ff @(posedge clk_pix) begin
        if (rst) begin
            hsync_p1 <= 1'b1;
            vsync_p1 <= 1'b1;
            de_p1    <= 1'b0;
            video    <= '{hsync: 1'b1, vsync: 1'b1, de: 1'b0, pix: rgb_t'(0)};
        end else begin
            hsync_p1 <= hsync;  // match buffer read latency
            vsync_p1 <= vsync;
            de_p1    <= de;
            video    <= '{hsync: hsync_p1, vsync: vsync_p1, de: de_p1, pix: fb_pix};
        end
    end

endmodule

//--- sim.f
hw/gfx_pkg.sv
hw/display_timings.sv
hw/framebuffer.sv
hw/draw_triangle_fill.sv
hw/draw_sequencer.sv
hw/triangles_top.sv
verif/triangles_asserts.sv
verif/tb_triangles.sv

//--- verif/tb_triangles.sv
////////////////////
// small 32x16 screen; each table row may clear first, then draws one triangle
// a decoy shape_start is sent while busy and must be ignored
////////////////////
`timescale 1ns/1ps

module tb_triangles;
    import gfx_pkg::*;

    localparam int H_RES = 32;
    localparam int V_RES = 16;
    localparam int FRAME = 800;  // 40 x 20 cycles per frame
    localparam int CLEAR_CYCLES = H_RES * V_RES + 2;
    localparam int DRAW_LIMIT = 20000;
    localparam int NROWS = 7;

    typedef struct packed {
        logic       clear_first;
        tri_shape_t shape;
    } step_t;

    logic clk_pix = 1'b0;
    logic rst = 1'b1;
    tri_shape_t shape = '0;
    logic shape_start = 1'b0;
    logic clear_start = 1'b0;
    logic draw_busy, draw_done;
    video_t video;
    step_t steps [NROWS];
    cidx_t shadow [V_RES][H_RES];  // expected colour index per pixel
    logic [31:0] lfsr = 32'hc46c;
    tri_shape_t rnd;

    triangles_top #(
        .H_RES(H_RES), .V_RES(V_RES), .H_FP(2), .H_SYNC(3),
        .H_BP(3), .V_FP(1), .V_SYNC(2), .V_BP(1)
    ) UUT (
        .clk_pix, .rst, .shape, .shape_start, .clear_start,
        .draw_busy, .draw_done, .video
    );

    always #20 clk_pix = ~clk_pix;

    task automatic fail_run(input string what);
        $display("%s", what);
        $display("Errors found");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_pix(input rgb_t got, input rgb_t exp, input int x, input int y);
        if (got !== exp) begin
            fail_run($sformatf("Mismatch at %0t: pixel (%0d,%0d) is %h, expected %h",
                $time, x, y, got, exp));
        end
    endtask

    task automatic check_video_idle(input video_t got);
        video_t exp;
        exp = '{hsync: 1'b1, vsync: 1'b1, de: 1'b0, pix: rgb_t'(0)};
        if (got !== exp) begin
            fail_run($sformatf("Mismatch at %0t: video is %h, expected idle %h",
                $time, got, exp));
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            fail_run($sformatf("Mismatch at %0t: %s is %b, expected %b", $time, what, got, exp));
        end
    endtask

    // fibonacci lfsr, taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic int take_bits(int n);
        int v;
        v = 0;
        repeat (n) begin
            lfsr = lfsr_next(lfsr);
            v = (v << 1) | int'(lfsr[0]);
        end
        return v;
    endfunction

    function automatic tri_shape_t make_tri(int x0, int y0, int x1, int y1,
                                            int x2, int y2, cidx_t c);
        return {coord_t'(x0), coord_t'(y0), coord_t'(x1), coord_t'(y1),
                coord_t'(x2), coord_t'(y2), c};
    endfunction

    task automatic random_tri(output tri_shape_t s);
        int c [7];
        for (int k = 0; k < 3; k++) begin
            c[2*k]   = take_bits(6) % 40 - 4;  // a few pixels past every edge
            c[2*k+1] = take_bits(5) % 24 - 4;
        end
        c[6] = take_bits(4);
        s = make_tri(c[0], c[1], c[2], c[3], c[4], c[5], cidx_t'(c[6]));
    endtask

    // (b - a) x (p - a)
    function automatic int edge_val(vertex_t a, vertex_t b, int px, int py);
        return (int'(b.x) - int'(a.x)) * (py - int'(a.y))
             - (int'(b.y) - int'(a.y)) * (px - int'(a.x));
    endfunction

    function automatic int lo3(int a, int b, int c);
        return (a < b) ? ((a < c) ? a : c) : ((b < c) ? b : c);
    endfunction

    function automatic int hi3(int a, int b, int c);
        return (a > b) ? ((a > c) ? a : c) : ((b > c) ? b : c);
    endfunction

    task automatic model_fill(input tri_shape_t s);
        int e0, e1, e2;
        logic in_box;
        for (int y = 0; y < V_RES; y++) begin
            for (int x = 0; x < H_RES; x++) begin
                in_box = x >= lo3(s.v0.x, s.v1.x, s.v2.x) && x <= hi3(s.v0.x, s.v1.x, s.v2.x)
                      && y >= lo3(s.v0.y, s.v1.y, s.v2.y) && y <= hi3(s.v0.y, s.v1.y, s.v2.y);
                e0 = edge_val(s.v0, s.v1, x, y);
                e1 = edge_val(s.v1, s.v2, x, y);
                e2 = edge_val(s.v2, s.v0, x, y);
                if (in_box && ((e0 >= 0 && e1 >= 0 && e2 >= 0) ||
                               (e0 <= 0 && e1 <= 0 && e2 <= 0))) begin
                    shadow[y][x] = s.colour;
                end
            end
        end
    endtask

    task automatic wait_done(input string what);
        int n;
        for (n = 0; n < DRAW_LIMIT; n++) begin
            @(negedge clk_pix);
            if (draw_done) break;
        end
        if (n == DRAW_LIMIT) fail_run({"Timeout waiting for draw_done after ", what});
    endtask

    task automatic scan_frame;
        int n;
        logic prev;
        prev = 1'b0;  // never treat a pulse already under way as a new one
        for (n = 0; n < 2 * FRAME; n++) begin
            @(negedge clk_pix);
            if (prev && !video.vsync) break;
            prev = video.vsync;
        end
        if (n == 2 * FRAME) fail_run("Timeout waiting for vsync to fall");
        for (int y = 0; y < V_RES; y++) begin
            for (int x = 0; x < H_RES; x++) begin
                for (n = 0; n < FRAME; n++) begin
                    @(negedge clk_pix);
                    if (video.de) break;
                end
                if (n == FRAME) fail_run("Timeout waiting for data enable");
                check_pix(video.pix, PALETTE[shadow[y][x]], x, y);
            end
        end
    endtask

    task automatic pulse_clear;
        @(posedge clk_pix);
        clear_start <= 1'b1;
        @(posedge clk_pix);
        clear_start <= 1'b0;
        for (int n = 1; n < CLEAR_CYCLES; n++) begin
            @(negedge clk_pix);
            check_flag(draw_done, 1'b0, "draw_done during clear");
            @(posedge clk_pix);
        end
        @(negedge clk_pix);
        check_flag(draw_done, 1'b1, "draw_done at end of clear");
        foreach (shadow[y, x]) shadow[y][x] = '0;
    endtask

    task automatic draw_shape(input tri_shape_t s);
        tri_shape_t decoy;
        decoy = make_tri(-40, -40, 80, -40, 20, 60, 4'hF);  // covers the whole screen
        @(posedge clk_pix);
        shape       <= s;
        shape_start <= 1'b1;
        @(posedge clk_pix);
        shape_start <= 1'b0;
        @(negedge clk_pix);
        check_flag(draw_busy, 1'b1, "draw_busy after shape_start");
        @(posedge clk_pix);
        shape       <= decoy;
        shape_start <= 1'b1;
        @(posedge clk_pix);
        shape_start <= 1'b0;
        wait_done("shape_start");
        model_fill(s);
    endtask

    initial begin
        steps[0] = {1'b1, make_tri(2, 2, 20, 4, 8, 13, 4'd3)};
        steps[1] = {1'b0, make_tri(10, 0, 12, 10, 28, 6, 4'd8)};  // other winding, overlaps
        steps[2] = {1'b1, make_tri(-6, -3, 20, 6, 5, 22, 4'd11)};  // partly off-screen
        steps[3] = {1'b0, make_tri(1, 14, 15, 7, 29, 0, 4'd14)};  // collinear
        for (int i = 4; i < NROWS; i++) begin
            random_tri(rnd);
            steps[i] = {1'b0, rnd};
        end

        repeat (4) begin
            @(posedge clk_pix);
            @(negedge clk_pix);
            check_video_idle(video);
            check_flag(draw_busy, 1'b0, "draw_busy during reset");
        end
        @(posedge clk_pix);
        rst <= 1'b0;
        repeat (2) begin
            @(negedge clk_pix);
            check_video_idle(video);
            check_flag(draw_busy, 1'b0, "draw_busy after reset");
        end

        for (int i = 0; i < NROWS; i++) begin
            if (steps[i].clear_first) begin
                pulse_clear();
                scan_frame();  // all black
            end
            draw_shape(steps[i].shape);
            scan_frame();
        end

        if (UUT.seq_inst.seq_checks.fail_count == 0) begin
            $display("No errors");
            $finish;
        end else begin
            fail_run("Assertion failures in draw_sequencer");
        end
    end

endmodule

//--- verif/triangles_asserts.sv
////////////////////
// bound into draw_sequencer, idle during reset
// fail_count counts failed assertions for the testbench
////////////////////
`timescale 1ns/1ps

module triangles_asserts (
    input logic clk_pix,
    input logic rst,
    input logic draw_busy,
    input logic draw_done,
    input logic wr_en
);
    int fail_count = 0;

    done_one_cycle: assert property (@(posedge clk_pix) disable iff (rst)
        draw_done |=> !draw_done)
        else begin $error("draw_done high two cycles in a row"); fail_count++; end

    write_while_busy: assert property (@(posedge clk_pix) disable iff (rst)
        wr_en |-> draw_busy)
        else begin $error("wr_en high while draw_busy low"); fail_count++; end

    busy_after_done: assert property (@(posedge clk_pix) disable iff (rst)
        draw_done |=> !draw_busy)
        else begin $error("draw_busy still high after draw_done"); fail_count++; end

endmodule

bind draw_sequencer triangles_asserts seq_checks (
    .clk_pix, .rst, .draw_busy, .draw_done, .wr_en
);
